/* verilog/gfx_defines.svh */
// shared sizes for the raster subsystem
// coordinate width, display timing, framebuffer geometry, renderer table length
`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

`define CORDW 16  // signed screen and draw coordinates

// display timing, blanking comes first so active area starts at 0
`define H_ACTIVE 64
`define H_BLANK 16
`define V_ACTIVE 48
`define V_BLANK 6

// framebuffer geometry
`define FB_WIDTH 32
`define FB_HEIGHT 16
`define FB_ADDRW 9  // 32x16 entries
`define FB_SCALE 2  // each fb pixel shown as 2x2
`define FB_OFFY 8  // first screen line of the picture

// colour
`define CIDXW 4
`define COLR_TRANS 12'h223  // shows background instead

// renderer
`define N_CMDS 6

`endif

/* verilog/display_pkg.sv */
// display side types
// palette and background band tables
`include "gfx_defines.svh"

package display_pkg;

    typedef logic signed [`CORDW-1:0] coord_t;
    typedef logic [`CIDXW-1:0] cidx_t;
    typedef logic [11:0] colr_t;  // 4 bits each of r, g, b

    // fixed 16-colour lookup, entry 0 is transparent
    localparam colr_t palette [16] = '{
        `COLR_TRANS, 12'h526, 12'hB35, 12'hE75, 12'hFC7, 12'hAE6, 12'h3B6, 12'h276,
        12'h236, 12'h36A, 12'h4AF, 12'h7EF, 12'hFFF, 12'h9AB, 12'h578, 12'h334
    };

    typedef struct packed {
        coord_t start;  // first screen line of band
        colr_t colr;
    } band_t;

    // sky fading down to grass below the castle
    localparam band_t bg_band [4] = '{'{0, 12'h239}, '{12, 12'h24A}, '{24, 12'h26C},
        '{40, 12'h370}};

endpackage

/* verilog/draw_pkg.sv */
// renderer enums and draw command struct
// fixed command list drawing the castle
`include "gfx_defines.svh"

package draw_pkg;

    typedef enum logic [1:0] {op_clear, op_rect, op_end} draw_op_e;

    typedef enum logic [1:0] {st_idle, st_load, st_fill, st_done} render_state_e;

    typedef struct packed {
        draw_op_e op;
        display_pkg::coord_t x0, y0, x1, y1;  // inclusive corners
        display_pkg::cidx_t cidx;
    } draw_cmd_t;

    localparam draw_cmd_t draw_cmds [`N_CMDS] = '{
        '{op_clear, 0, 0, 0, 0, 0},  // whole buffer to transparent
        '{op_rect, 4, 7, 27, 15, 13},  // wall
        '{op_rect, 4, 2, 9, 6, 14},  // left tower
        '{op_rect, 22, 2, 27, 6, 14},  // right tower
        '{op_rect, 24, 12, 40, 20, 3},  // runs off right and bottom
        '{op_end, 0, 0, 0, 0, 0}
    };

endpackage

/* verilog/fb_write_if.sv */
// pixel write stream from renderer to address pipeline
`timescale 1ns/1ps

interface fb_write_if;

    display_pkg::coord_t x;  // may lie outside the buffer
    display_pkg::coord_t y;
    display_pkg::cidx_t cidx;
    logic drawing;  // one pixel per high cycle

    modport src (output x, y, cidx, drawing);
    modport dst (input x, y, cidx, drawing);

endinterface

/* verilog/display_timing.sv */
// screen scan counters
// de level plus line and frame strobes
`timescale 1ns/1ps
`include "gfx_defines.svh"

module display_timing (
    input  logic clk_sys,
    input  logic rst_sys,
    output display_pkg::coord_t sx,
    output display_pkg::coord_t sy,
    output logic de,
    output logic frame,
    output logic line
);

    localparam display_pkg::coord_t H_STA = -`H_BLANK;  // blanking start
    localparam display_pkg::coord_t H_END = `H_ACTIVE - 1;
    localparam display_pkg::coord_t V_STA = -`V_BLANK;
    localparam display_pkg::coord_t V_END = `V_ACTIVE - 1;

    always_ff @(posedge clk_sys) begin
        if (sx == H_END) begin  // end of line
            sx <= H_STA;
            sy <= (sy == V_END) ? V_STA : display_pkg::coord_t'(sy + 1);
        end else begin
            sx <= display_pkg::coord_t'(sx + 1);
        end
        // park on last pixel so the first cycle out of reset starts a frame
        if (rst_sys) begin
            sx <= H_END;
            sy <= V_END;
        end
    end

    always_comb begin
        de = (sx >= 0 && sy >= 0);
        line = (sx == H_STA);  // start of horizontal blanking
        frame = (line && sy == V_STA);  // first blanking line
    end

endmodule

/* verilog/render_rects.sv */
// filled rectangle renderer
// walks draw_cmds once, one pixel per cycle
`timescale 1ns/1ps
`include "gfx_defines.svh"

module render_rects (
    input  logic clk_sys,
    input  logic rst_sys,
    input  logic start,  // frame pulse
    fb_write_if.src wr,
    output logic done
);

    localparam int IDXW = $clog2(`N_CMDS);

    draw_pkg::render_state_e state;
    draw_pkg::draw_cmd_t cmd;
    logic [IDXW-1:0] cmd_idx;
    display_pkg::coord_t x_start;  // left edge, x returns here each row
    display_pkg::coord_t x_end;
    display_pkg::coord_t y_end;

    always_comb cmd = draw_pkg::draw_cmds[cmd_idx];

    always_ff @(posedge clk_sys) begin
        case (state)
            draw_pkg::st_idle: begin
                cmd_idx <= '0;
                if (start) state <= draw_pkg::st_load;
            end
            draw_pkg::st_load: begin
                wr.cidx <= cmd.cidx;
                if (cmd.op == draw_pkg::op_end) begin
                    state <= draw_pkg::st_done;
                end else begin
                    cmd_idx <= cmd_idx + 1'b1;
                    state <= draw_pkg::st_fill;
                    if (cmd.op == draw_pkg::op_clear) begin  // full buffer
                        x_start <= '0;
                        x_end <= display_pkg::coord_t'(`FB_WIDTH - 1);
                        y_end <= display_pkg::coord_t'(`FB_HEIGHT - 1);
                        wr.x <= '0;
                        wr.y <= '0;
                    end else begin
                        x_start <= cmd.x0;
                        x_end <= cmd.x1;
                        y_end <= cmd.y1;
                        wr.x <= cmd.x0;
                        wr.y <= cmd.y0;
                    end
                end
            end
            draw_pkg::st_fill: begin
                if (wr.x == x_end) begin  // row finished
                    wr.x <= x_start;
                    if (wr.y == y_end) state <= draw_pkg::st_load;  // rect finished
                    else wr.y <= display_pkg::coord_t'(wr.y + 1);
                end else begin
                    wr.x <= display_pkg::coord_t'(wr.x + 1);
                end
            end
            default: state <= draw_pkg::st_done;  // stays until reset
        endcase
        if (rst_sys) begin
            state <= draw_pkg::st_idle;
            cmd_idx <= '0;
        end
    end

    assign wr.drawing = (state == draw_pkg::st_fill);
    assign done = (state == draw_pkg::st_done);

endmodule

/* verilog/bitmap_addr.sv */
// coordinate to framebuffer address, 3 cycle pipeline
// clipping gates the write enable
`timescale 1ns/1ps
`include "gfx_defines.svh"

module bitmap_addr (
    input  logic clk_sys,
    input  logic rst_sys,
    fb_write_if.dst wr,
    output logic [`FB_ADDRW-1:0] addr,
    output display_pkg::cidx_t cidx,
    output logic we
);

    localparam int AW = `FB_ADDRW;

    display_pkg::coord_t x1, y1;  // stage 1
    display_pkg::coord_t x2, row2;  // stage 2
    logic clip;
    logic [2:0] clip_sr, draw_sr;
    display_pkg::cidx_t cidx_sr [3];

    always_comb clip = (wr.x < 0 || wr.x >= `FB_WIDTH || wr.y < 0 || wr.y >= `FB_HEIGHT);

    always_ff @(posedge clk_sys) begin
        x1 <= wr.x;
        y1 <= wr.y;
        x2 <= x1;
        row2 <= display_pkg::coord_t'(y1 * `FB_WIDTH);  // row start
        addr <= AW'(row2 + x2);
        clip_sr <= {clip_sr[1:0], clip};
        draw_sr <= {draw_sr[1:0], wr.drawing};
        cidx_sr[0] <= wr.cidx;  // colour rides alongside
        cidx_sr[1] <= cidx_sr[0];
        cidx_sr[2] <= cidx_sr[1];
        if (rst_sys) draw_sr <= '0;
    end

    assign we = draw_sr[2] && !clip_sr[2];  // no wrap into other rows
    assign cidx = cidx_sr[2];

endmodule

/* verilog/framebuffer_bram.sv */
// simple dual-port framebuffer memory, registered read
`timescale 1ns/1ps
`include "gfx_defines.svh"

module framebuffer_bram (
    input  logic clk_sys,
    input  logic we,
    input  logic [`FB_ADDRW-1:0] addr_write,
    input  display_pkg::cidx_t data_in,
    input  logic [`FB_ADDRW-1:0] addr_read,
    output display_pkg::cidx_t data_out
);

    display_pkg::cidx_t mem [2**`FB_ADDRW];  // one colour index per pixel

    always_ff @(posedge clk_sys) begin
        if (we) mem[addr_write] <= data_in;
        data_out <= mem[addr_read];  // 1 cycle read latency
    end

endmodule

/* verilog/linebuffer.sv */
// framebuffer row fetch into two line banks
// scaled readout of the display bank
`timescale 1ns/1ps
`include "gfx_defines.svh"

module linebuffer (
    input  logic clk_sys,
    input  logic rst_sys,
    input  logic frame,
    input  logic line,
    input  display_pkg::coord_t sy,
    input  display_pkg::coord_t sx,
    output logic [`FB_ADDRW-1:0] fb_addr,
    input  display_pkg::cidx_t fb_data,
    output display_pkg::cidx_t cidx,
    output logic paint
);

    localparam int COLW = $clog2(`FB_WIDTH);
    localparam int SCLW = $clog2(`FB_SCALE) + 1;
    localparam int FETCH_FIRST = `FB_OFFY - 1;  // line before the picture
    localparam int FETCH_LAST = FETCH_FIRST + (`FB_HEIGHT - 1) * `FB_SCALE;

    logic [SCLW-1:0] scale_cnt;  // line within current scale group
    logic fetch_line;
    logic fetch_en, write_en;  // write_en matches bram latency
    logic [COLW-1:0] fetch_col, write_col;
    logic wr_bank, rd_bank;
    display_pkg::cidx_t bank [2][`FB_WIDTH];

    always_comb fetch_line = line && sy >= FETCH_FIRST && sy <= FETCH_LAST
        && (sy == FETCH_FIRST || scale_cnt == SCLW'(`FB_SCALE - 1));

    always_ff @(posedge clk_sys) begin
        if (line) begin
            scale_cnt <= fetch_line ? '0 : scale_cnt + 1'b1;
            rd_bank <= wr_bank;  // bank filled by the previous fetch
        end
        if (fetch_line) begin
            fetch_en <= 1'b1;
            fetch_col <= '0;
            wr_bank <= !wr_bank;
        end else if (fetch_en) begin
            fetch_col <= fetch_col + 1'b1;
            fb_addr <= fb_addr + 1'b1;  // runs on into the next row
            if (fetch_col == COLW'(`FB_WIDTH - 1)) fetch_en <= 1'b0;
        end
        if (frame) fb_addr <= '0;  // row 0
        write_en <= fetch_en;
        write_col <= fetch_col;
        if (rst_sys) begin
            scale_cnt <= '0;
            fetch_en <= 1'b0;
            write_en <= 1'b0;
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (write_en) bank[wr_bank][write_col] <= fb_data;
        cidx <= bank[rd_bank][sx[COLW:1]];  // sx/2 for 2x scale
        paint <= sx >= 0 && sx < `FB_WIDTH * `FB_SCALE
            && sy >= `FB_OFFY && sy < `FB_OFFY + `FB_HEIGHT * `FB_SCALE;
        if (rst_sys) paint <= 1'b0;
    end

endmodule

/* verilog/pixel_out.sv */
// palette lookup, background bands, output registers
// all outputs 2 cycles behind display timing
`timescale 1ns/1ps
`include "gfx_defines.svh"

module pixel_out (
    input  logic clk_sys,
    input  logic rst_sys,
    input  display_pkg::coord_t sx,
    input  display_pkg::coord_t sy,
    input  logic de,
    input  logic frame,
    input  display_pkg::cidx_t cidx,  // 1 cycle behind sx
    input  logic paint,
    output display_pkg::coord_t out_sx,
    output display_pkg::coord_t out_sy,
    output logic out_de,
    output logic out_frame,
    output logic [7:0] r,
    output logic [7:0] g,
    output logic [7:0] b
);

    display_pkg::coord_t sx_d, sy_d;  // aligned with linebuffer output
    logic de_d, frame_d;
    display_pkg::colr_t pix_colr, bg_colr, colr;

    always_ff @(posedge clk_sys) begin
        sx_d <= sx;
        sy_d <= sy;
        de_d <= de;
        frame_d <= frame;
        if (rst_sys) begin
            de_d <= 1'b0;
            frame_d <= 1'b0;
        end
    end

    always_comb begin
        pix_colr = paint ? display_pkg::palette[cidx] : '0;  // black outside picture
        bg_colr = '0;
        for (int i = 0; i < $size(display_pkg::bg_band); i++) begin
            if (sy_d >= display_pkg::bg_band[i].start) bg_colr = display_pkg::bg_band[i].colr;
        end
        colr = (de_d && pix_colr == `COLR_TRANS) ? bg_colr : pix_colr;
    end

    always_ff @(posedge clk_sys) begin
        out_sx <= sx_d;
        out_sy <= sy_d;
        out_de <= de_d;
        out_frame <= frame_d;
        r <= de_d ? {2{colr[11:8]}} : 8'h00;  // nibble doubled to 8 bits
        g <= de_d ? {2{colr[7:4]}} : 8'h00;
        b <= de_d ? {2{colr[3:0]}} : 8'h00;
        if (rst_sys) begin
            out_de <= 1'b0;
            out_frame <= 1'b0;
            r <= 8'h00;
            g <= 8'h00;
            b <= 8'h00;
        end
    end

endmodule

/* verilog/castle_top.sv */
// castle raster subsystem top level
// timing, renderer, framebuffer, linebuffer and output stage
`timescale 1ns/1ps
`include "gfx_defines.svh"

module castle_top (
    input  logic clk_sys,
    input  logic rst_sys,
    output display_pkg::coord_t sx,
    output display_pkg::coord_t sy,
    output logic de,
    output logic frame,
    output logic [7:0] r,
    output logic [7:0] g,
    output logic [7:0] b
);

    display_pkg::coord_t tim_sx, tim_sy;  // raw scan position
    logic tim_de, tim_frame, tim_line;
    logic render_done;  // not used further
    logic [`FB_ADDRW-1:0] fb_addr_write, fb_addr_read;
    display_pkg::cidx_t fb_cidx_write, fb_cidx_read;
    logic fb_we;
    display_pkg::cidx_t lb_cidx;
    logic lb_paint;

    fb_write_if draw_if ();

    display_timing timing0 (
        .clk_sys(clk_sys),
        .rst_sys(rst_sys),
        .sx(tim_sx),
        .sy(tim_sy),
        .de(tim_de),
        .frame(tim_frame),
        .line(tim_line)
    );

    render_rects render0 (
        .clk_sys(clk_sys),
        .rst_sys(rst_sys),
        .start(tim_frame),  // first frame after reset
        .wr(draw_if.src),
        .done(render_done)
    );

    bitmap_addr addr0 (
        .clk_sys(clk_sys),
        .rst_sys(rst_sys),
        .wr(draw_if.dst),
        .addr(fb_addr_write),
        .cidx(fb_cidx_write),
        .we(fb_we)
    );

    framebuffer_bram fb0 (
        .clk_sys(clk_sys),
        .we(fb_we),
        .addr_write(fb_addr_write),
        .data_in(fb_cidx_write),
        .addr_read(fb_addr_read),
        .data_out(fb_cidx_read)
    );

    linebuffer lb0 (
        .clk_sys(clk_sys),
        .rst_sys(rst_sys),
        .frame(tim_frame),
        .line(tim_line),
        .sy(tim_sy),
        .sx(tim_sx),
        .fb_addr(fb_addr_read),
        .fb_data(fb_cidx_read),
        .cidx(lb_cidx),
        .paint(lb_paint)
    );

    pixel_out out0 (
        .clk_sys(clk_sys),
        .rst_sys(rst_sys),
        .sx(tim_sx),
        .sy(tim_sy),
        .de(tim_de),
        .frame(tim_frame),
        .cidx(lb_cidx),
        .paint(lb_paint),
        .out_sx(sx),
        .out_sy(sy),
        .out_de(de),
        .out_frame(frame),
        .r(r),
        .g(g),
        .b(b)
    );

endmodule

/* sim/tb_castle.sv */
// directed testbench for castle_top
// reference model of the framebuffer picture, scan checks per frame
`timescale 1ns/1ps
`include "gfx_defines.svh"

module tb_castle;

    localparam int FRAME_CYCLES = (`H_ACTIVE + `H_BLANK) * (`V_ACTIVE + `V_BLANK);  // 4320
    localparam int LIMIT = 6 * FRAME_CYCLES + 4080;  // six frames plus margin, 30000

    logic clk_sys;
    logic rst_sys;
    display_pkg::coord_t sx, sy;
    logic de, frame;
    logic [7:0] r, g, b;

    int checks;
    int errors;
    int cycle_cnt;
    display_pkg::cidx_t fb_model [`FB_HEIGHT][`FB_WIDTH];  // expected framebuffer

    castle_top dut0 (
        .clk_sys(clk_sys),
        .rst_sys(rst_sys),
        .sx(sx),
        .sy(sy),
        .de(de),
        .frame(frame),
        .r(r),
        .g(g),
        .b(b)
    );

    always #50 clk_sys = ~clk_sys;  // 100 ns period

    // watchdog over the whole run
    always @(posedge clk_sys) begin
        cycle_cnt++;
        if (cycle_cnt >= LIMIT) begin
            $display("timeout after %0d cycles, run did not finish", cycle_cnt);
            $display("Checks failed");
            $finish;
        end
    end

    // apply draw commands in order, dropping pixels off the buffer
    task automatic build_model();
        draw_pkg::draw_cmd_t cmd;
        for (int i = 0; i < `N_CMDS; i++) begin
            cmd = draw_pkg::draw_cmds[i];
            if (cmd.op == draw_pkg::op_clear) begin
                for (int y = 0; y < `FB_HEIGHT; y++)
                    for (int x = 0; x < `FB_WIDTH; x++) fb_model[y][x] = cmd.cidx;
            end else if (cmd.op == draw_pkg::op_rect) begin
                for (int y = cmd.y0; y <= cmd.y1; y++)
                    for (int x = cmd.x0; x <= cmd.x1; x++)
                        if (x >= 0 && x < `FB_WIDTH && y >= 0 && y < `FB_HEIGHT)
                            fb_model[y][x] = cmd.cidx;  // clipped, never wrapped
            end
        end
    endtask

    function automatic logic in_picture(int x, int y);
        return x >= 0 && x < `FB_WIDTH * `FB_SCALE
            && y >= `FB_OFFY && y < `FB_OFFY + `FB_HEIGHT * `FB_SCALE;
    endfunction

    // last band starting at or above this line
    function automatic display_pkg::colr_t band_colr(int y);
        display_pkg::colr_t c;
        c = '0;
        for (int i = 0; i < $size(display_pkg::bg_band); i++)
            if (y >= display_pkg::bg_band[i].start) c = display_pkg::bg_band[i].colr;
        return c;
    endfunction

    // palette colour of the fb pixel behind a screen pixel, black outside
    function automatic display_pkg::colr_t model_colr(int x, int y);
        if (!in_picture(x, y)) return '0;
        return display_pkg::palette[fb_model[(y - `FB_OFFY) / `FB_SCALE][x / `FB_SCALE]];
    endfunction

    function automatic display_pkg::colr_t expected_colr(int x, int y);
        display_pkg::colr_t c;
        c = model_colr(x, y);
        if (in_picture(x, y) && c == `COLR_TRANS) c = band_colr(y);  // background shows
        return c;
    endfunction

    function automatic logic [23:0] expand(display_pkg::colr_t c);
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};  // nibble doubled
    endfunction

    task automatic compare_pixel(string test, display_pkg::colr_t exp);
        checks++;
        if ({r, g, b} !== expand(exp)) begin
            errors++;
            $display("** Error %s: pixel (%0d,%0d) expected %h actual %h",
                test, sx, sy, expand(exp), {r, g, b});
        end
    endtask

    task automatic wait_frame();
        while (frame !== 1'b1) @(negedge clk_sys);
    endtask

    task automatic reset_state();
        checks++;
        if ({de, frame, r, g, b} !== 26'h0) begin
            errors++;
            $display("** Error reset_state: outputs expected 0 actual %h", {de, frame, r, g, b});
        end
    endtask

    // one frame from pulse to pulse, de run per line
    task automatic frame_timing();
        int cycles;
        int lines;
        int col;
        cycles = 0;
        lines = 0;
        col = 0;
        do begin
            @(negedge clk_sys);
            cycles++;
            if (de) begin
                checks++;
                if (sx != col) begin
                    errors++;
                    $display("** Error frame_timing: sx expected %0d actual %0d", col, sx);
                end
                checks++;
                if (sy != lines) begin  // active line number
                    errors++;
                    $display("** Error frame_timing: sy expected %0d actual %0d", lines, sy);
                end
                col++;
            end else if (col != 0) begin  // de just fell
                lines++;
                checks++;
                if (col != `H_ACTIVE) begin
                    errors++;
                    $display("** Error frame_timing: de run expected %0d actual %0d",
                        `H_ACTIVE, col);
                end
                col = 0;
            end
        end while (!frame);
        checks += 2;
        if (cycles != FRAME_CYCLES) begin
            errors++;
            $display("** Error frame_timing: frame period expected %0d actual %0d",
                FRAME_CYCLES, cycles);
        end
        if (lines != `V_ACTIVE) begin
            errors++;
            $display("** Error frame_timing: active lines expected %0d actual %0d",
                `V_ACTIVE, lines);
        end
    endtask

    task automatic picture();
        int x, y;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            x = sx;
            y = sy;
            if (de && in_picture(x, y) && model_colr(x, y) != `COLR_TRANS)
                compare_pixel("picture", model_colr(x, y));
            @(negedge clk_sys);
        end
    endtask

    task automatic background();
        int x, y;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            x = sx;
            y = sy;
            if (de && in_picture(x, y) && model_colr(x, y) == `COLR_TRANS)
                compare_pixel("background", band_colr(y));
            @(negedge clk_sys);
        end
    endtask

    // cells where a wrapped address would land, and lines below the picture
    task automatic clipping();
        int x, y, col, row;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            x = sx;
            y = sy;
            col = x / `FB_SCALE;
            row = (y - `FB_OFFY) / `FB_SCALE;
            if (de && in_picture(x, y) && ((row >= 13 && col <= 8) || (row <= 4 && col >= 24)))
                compare_pixel("clipping", expected_colr(x, y));
            if (de && !in_picture(x, y) && y >= `FB_OFFY + `FB_HEIGHT * `FB_SCALE)
                compare_pixel("clipping", '0);
            @(negedge clk_sys);
        end
    endtask

    task automatic blank_black();
        int x, y;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            x = sx;
            y = sy;
            if (!de || !in_picture(x, y)) compare_pixel("blank_black", '0);
            @(negedge clk_sys);
        end
    endtask

    initial begin
        clk_sys = 1'b0;
        rst_sys = 1'b1;
        checks = 0;
        errors = 0;
        cycle_cnt = 0;
        build_model();
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        rst_sys = 1'b0;  // released on falling edge
        reset_state();
        @(negedge clk_sys);
        reset_state();
        wait_frame();  // frame 0
        frame_timing();  // ends on frame 1 pulse
        @(negedge clk_sys);
        wait_frame();  // frame 2, picture settled
        picture();
        background();
        clipping();
        blank_black();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+verilog
verilog/display_pkg.sv
verilog/draw_pkg.sv
verilog/fb_write_if.sv
verilog/display_timing.sv
verilog/render_rects.sv
verilog/bitmap_addr.sv
verilog/framebuffer_bram.sv
verilog/linebuffer.sv
verilog/pixel_out.sv
verilog/castle_top.sv
sim/tb_castle.sv
